// ==== source/plus_asic_params.svh ====
`ifndef PLUS_ASIC_PARAMS_SVH
`define PLUS_ASIC_PARAMS_SVH

// CPU window of the ASIC page
`define PLUS_PAGE_BASE 16'h4000
`define PLUS_PAGE_END 16'h7FFF

// Register region, decoded on the 13-bit page offset
`define PLUS_REG_BASE 16'h6000

// High address byte of the mode register port
`define PLUS_CRTC_PORT 8'hBC

// ASIC RAM geometry
`define PLUS_RAM_DEPTH 16384
`define PLUS_RAM_AW 14

// Palette bytes, odd ones hold only a nibble
`define PLUS_PAL_FIRST 13'h0400
`define PLUS_PAL_LAST 13'h043F

// Captured registers
`define PLUS_OFS_PRI 13'h0800
`define PLUS_OFS_SCROLL 13'h0804
`define PLUS_OFS_VECTOR 13'h0805

// Read-only offsets, analogue base covers four bytes and pads ignore bit 1
`define PLUS_OFS_ANALOG 13'h0808
`define PLUS_OFS_PAD_HI 13'h080C
`define PLUS_OFS_PAD_LO 13'h080D
`define PLUS_OFS_DMA 13'h0C0F

// ASIC mode bytes that enable the page
`define PLUS_UNLOCK_A 8'h02
`define PLUS_UNLOCK_B 8'h62
`define PLUS_UNLOCK_C 8'h82

`endif

// ==== source/plus_asic_pkg.sv ====
`include "plus_asic_params.svh"

package plus_asic_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [`PLUS_RAM_AW-1:0] ram_addr_t;

    // Four 6-bit analogue channels, channel 0 in the low bits
    typedef logic [3:0][5:0] analog_bank_t;

    // One written byte, seen either as soft scroll or as the vector
    typedef union packed {
        struct packed {
            logic       border;
            logic [2:0] vert;
            logic [3:0] horiz;
        } scroll;
        struct packed {
            logic [4:0] vector;
            logic [2:0] unused;
        } vec;
    } asic_reg_byte_u;

    typedef enum logic [1:0] {
        REG_NONE,
        REG_PRI,
        REG_SCROLL,
        REG_VECTOR
    } reg_target_e;

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_RAM,
        SRC_ANALOG,
        SRC_PAD_HI,
        SRC_PAD_LO,
        SRC_DMA,
        SRC_SDRAM,
        SRC_OPEN
    } read_src_e;

endpackage

// ==== source/asic_page_decoder.sv ====
`timescale 1ns/1ns
`include "plus_asic_params.svh"

module asic_page_decoder
    import plus_asic_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        plus_mode,
    input  logic        use_asic,
    input  cpu_addr_t   cpu_addr,
    input  byte_t       cpu_data_in,
    input  logic        cpu_wr,
    input  logic        cpu_rd,
    output logic        asic_unlocked,
    output logic        sdram_oe,
    output logic        sdram_we,
    output ram_addr_t   ram_addr,
    output byte_t       ram_din,
    output logic        ram_wr,
    output logic        ram_rd,
    output reg_target_e reg_target,
    output read_src_e   read_src,
    output logic [1:0]  analog_sel
);

    logic [12:0] page_ofs;
    logic        page_hit;
    logic        reg_region;
    logic        port_write;
    logic        unlock_match;
    logic        asic_enabled;
    logic [1:0]  rmr2_page;
    logic        asic_access;
    logic        pal_odd;
    logic        analog_hit;
    logic        pad_hi_hit;
    logic        pad_lo_hit;
    logic        dma_hit;

    assign page_ofs   = cpu_addr[12:0];
    assign page_hit   = (cpu_addr >= `PLUS_PAGE_BASE) && (cpu_addr <= `PLUS_PAGE_END);
    assign reg_region = page_hit && (cpu_addr >= `PLUS_REG_BASE);
    assign port_write = cpu_wr && (cpu_addr[15:8] == `PLUS_CRTC_PORT) && !cpu_addr[0];

    assign unlock_match = (cpu_data_in == `PLUS_UNLOCK_A) ||
                          (cpu_data_in == `PLUS_UNLOCK_B) ||
                          (cpu_data_in == `PLUS_UNLOCK_C);

    // Mode registers, select code in the low five data bits
    // Code 0 is the configuration byte and has no effect on the page
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rmr2_page    <= 2'b00;
            asic_enabled <= 1'b0;
        end else if (port_write) begin
            casez (cpu_data_in[4:0])
                // RMR2 code leaves bits 4 and 3 free as the page bits
                5'b??001: rmr2_page <= cpu_data_in[4:3];
                5'b00010: asic_enabled <= unlock_match && plus_mode;
                default: ;
            endcase
        end
    end

    assign asic_unlocked = asic_enabled;

    // CPU sees ASIC RAM only with every gate open
    assign asic_access = page_hit && plus_mode && use_asic && asic_enabled &&
                         rmr2_page[1] && rmr2_page[0];

    assign sdram_oe = page_hit && !asic_access && cpu_rd;
    assign sdram_we = page_hit && !asic_access && cpu_wr;

    assign pal_odd = reg_region && page_ofs[0] &&
                     (page_ofs >= `PLUS_PAL_FIRST) && (page_ofs <= `PLUS_PAL_LAST);

    assign analog_hit = ({page_ofs[12:2], 2'b00} == `PLUS_OFS_ANALOG);
    assign pad_hi_hit = ({page_ofs[12:2], 1'b0, page_ofs[0]} == `PLUS_OFS_PAD_HI);
    assign pad_lo_hit = ({page_ofs[12:2], 1'b0, page_ofs[0]} == `PLUS_OFS_PAD_LO);
    assign dma_hit    = (page_ofs == `PLUS_OFS_DMA);

    assign ram_addr   = cpu_addr[`PLUS_RAM_AW-1:0];
    assign ram_din    = pal_odd ? {4'h0, cpu_data_in[3:0]} : cpu_data_in;
    assign ram_wr     = cpu_wr && asic_access;
    assign ram_rd     = (read_src == SRC_RAM);
    assign analog_sel = cpu_addr[1:0];

    // Register write target
    always_comb begin
        reg_target = REG_NONE;
        if (cpu_wr && asic_access && reg_region) begin
            case (page_ofs)
                `PLUS_OFS_PRI:    reg_target = REG_PRI;
                `PLUS_OFS_SCROLL: reg_target = REG_SCROLL;
                `PLUS_OFS_VECTOR: reg_target = REG_VECTOR;
                default:          reg_target = REG_NONE;
            endcase
        end
    end

    // Where the read data comes from
    always_comb begin
        read_src = SRC_NONE;
        if (cpu_rd) begin
            if (!page_hit) begin
                read_src = SRC_OPEN;
            end else if (!asic_access) begin
                read_src = SRC_SDRAM;
            end else if (reg_region && analog_hit) begin
                read_src = SRC_ANALOG;
            end else if (reg_region && pad_hi_hit) begin
                read_src = SRC_PAD_HI;
            end else if (reg_region && pad_lo_hit) begin
                read_src = SRC_PAD_LO;
            end else if (reg_region && dma_hit) begin
                read_src = SRC_DMA;
            end else begin
                read_src = SRC_RAM;
            end
        end
    end

endmodule

// ==== source/asic_ram.sv ====
`timescale 1ns/1ns
`include "plus_asic_params.svh"

module asic_ram
    import plus_asic_pkg::*;
(
    input  logic      clk_sys,
    input  ram_addr_t ram_addr,
    input  byte_t     ram_din,
    input  logic      ram_wr,
    input  logic      ram_rd,
    output byte_t     ram_q
);

    byte_t mem [0:`PLUS_RAM_DEPTH-1];

    // Single port, write and registered read
    always_ff @(posedge clk_sys) begin
        if (ram_wr) begin
            mem[ram_addr] <= ram_din;
        end
    end

    // Output holds between reads
    always_ff @(posedge clk_sys) begin
        if (ram_rd) begin
            ram_q <= mem[ram_addr];
        end
    end

endmodule

// ==== source/asic_register_page.sv ====
`timescale 1ns/1ns

module asic_register_page
    import plus_asic_pkg::*;
(
    input  logic           clk_sys,
    input  logic           reset,
    input  asic_reg_byte_u cpu_data_in,
    input  reg_target_e    reg_target,
    input  read_src_e      read_src,
    input  logic [1:0]     analog_sel,
    input  analog_bank_t   analog_in,
    input  logic [2:0]     dma_status,
    input  byte_t          sdram_dout,
    input  byte_t          ram_q,
    output byte_t          cpu_data_out,
    output byte_t          pri_line,
    output logic [3:0]     soft_scroll_h,
    output logic [2:0]     soft_scroll_v,
    output logic           extend_border,
    output logic [4:0]     interrupt_vector
);

    read_src_e held_src;
    byte_t     held_data;
    byte_t     read_value;

    // Captured fields
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pri_line         <= 8'h00;
            soft_scroll_h    <= 4'h0;
            soft_scroll_v    <= 3'h0;
            extend_border    <= 1'b0;
            interrupt_vector <= 5'h00;
        end else begin
            case (reg_target)
                REG_PRI: begin
                    pri_line <= cpu_data_in;
                end
                REG_SCROLL: begin
                    soft_scroll_h <= cpu_data_in.scroll.horiz;
                    soft_scroll_v <= cpu_data_in.scroll.vert;
                    extend_border <= cpu_data_in.scroll.border;
                end
                REG_VECTOR: begin
                    interrupt_vector <= cpu_data_in.vec.vector;
                end
                default: ;
            endcase
        end
    end

    // Non-RAM read value
    always_comb begin
        case (read_src)
            SRC_ANALOG: read_value = {2'b00, analog_in[analog_sel]};
            SRC_PAD_HI: read_value = 8'h3F;
            SRC_PAD_LO: read_value = 8'h00;
            SRC_DMA:    read_value = {dma_status, 5'b00000};
            SRC_SDRAM:  read_value = sdram_dout;
            default:    read_value = 8'hFF;
        endcase
    end

    // Source and value of the last read
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            held_src  <= SRC_NONE;
            held_data <= 8'hFF;
        end else if (read_src != SRC_NONE) begin
            held_src  <= read_src;
            held_data <= read_value;
        end
    end

    // RAM data arrives from the RAM register in the same cycle
    assign cpu_data_out = (held_src == SRC_RAM) ? ram_q : held_data;

endmodule

// ==== source/plus_asic.sv ====
`timescale 1ns/1ns

module plus_asic
    import plus_asic_pkg::*;
(
    input  logic         clk_sys,
    input  logic         reset,
    input  logic         plus_mode,
    input  logic         use_asic,
    input  cpu_addr_t    cpu_addr,
    input  byte_t        cpu_data_in,
    input  logic         cpu_wr,
    input  logic         cpu_rd,
    output byte_t        cpu_data_out,
    output logic         asic_unlocked,
    output logic         sdram_oe,
    output logic         sdram_we,
    input  byte_t        sdram_dout,
    input  analog_bank_t analog_in,
    input  logic [2:0]   dma_status,
    output byte_t        pri_line,
    output logic [3:0]   soft_scroll_h,
    output logic [2:0]   soft_scroll_v,
    output logic         extend_border,
    output logic [4:0]   interrupt_vector
);

    ram_addr_t   ram_addr;
    byte_t       ram_din;
    logic        ram_wr;
    logic        ram_rd;
    byte_t       ram_q;
    reg_target_e reg_target;
    read_src_e   read_src;
    logic [1:0]  analog_sel;

    asic_page_decoder u_decoder (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .plus_mode     (plus_mode),
        .use_asic      (use_asic),
        .cpu_addr      (cpu_addr),
        .cpu_data_in   (cpu_data_in),
        .cpu_wr        (cpu_wr),
        .cpu_rd        (cpu_rd),
        .asic_unlocked (asic_unlocked),
        .sdram_oe      (sdram_oe),
        .sdram_we      (sdram_we),
        .ram_addr      (ram_addr),
        .ram_din       (ram_din),
        .ram_wr        (ram_wr),
        .ram_rd        (ram_rd),
        .reg_target    (reg_target),
        .read_src      (read_src),
        .analog_sel    (analog_sel)
    );

    asic_ram u_ram (
        .clk_sys  (clk_sys),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_wr   (ram_wr),
        .ram_rd   (ram_rd),
        .ram_q    (ram_q)
    );

    // Register page reads the raw CPU byte through the union
    asic_register_page u_regs (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .cpu_data_in      (asic_reg_byte_u'(cpu_data_in)),
        .reg_target       (reg_target),
        .read_src         (read_src),
        .analog_sel       (analog_sel),
        .analog_in        (analog_in),
        .dma_status       (dma_status),
        .sdram_dout       (sdram_dout),
        .ram_q            (ram_q),
        .cpu_data_out     (cpu_data_out),
        .pri_line         (pri_line),
        .soft_scroll_h    (soft_scroll_h),
        .soft_scroll_v    (soft_scroll_v),
        .extend_border    (extend_border),
        .interrupt_vector (interrupt_vector)
    );

endmodule

// ==== tb/plus_asic_ref_model.svh ====
`ifndef PLUS_ASIC_REF_MODEL_SVH
`define PLUS_ASIC_REF_MODEL_SVH

// Expected state, updated once per bus cycle
logic       exp_enabled;
logic [1:0] exp_rmr2;
logic [7:0] exp_read;
logic [7:0] exp_pri;
logic [3:0] exp_scroll_h;
logic [2:0] exp_scroll_v;
logic       exp_border;
logic [4:0] exp_vector;

// RAM bytes written so far, keyed by page index
logic [7:0] ram_map [logic [13:0]];

function automatic void clear_model();
    exp_enabled  = 1'b0;
    exp_rmr2     = 2'b00;
    exp_read     = 8'hFF;
    exp_pri      = 8'h00;
    exp_scroll_h = 4'h0;
    exp_scroll_v = 3'h0;
    exp_border   = 1'b0;
    exp_vector   = 5'h00;
    ram_map.delete();
endfunction

function automatic logic in_page(input logic [15:0] addr);
    return (addr >= 16'h4000) && (addr <= 16'h7FFF);
endfunction

// Every gate open for the CPU
function automatic logic page_open(input logic [15:0] addr, input logic plus,
                                   input logic asic_on);
    return in_page(addr) && plus && asic_on && exp_enabled && (exp_rmr2 == 2'b11);
endfunction

function automatic logic [7:0] predict_read(input logic [15:0] addr, input logic plus,
        input logic asic_on, input logic [7:0] sd, input analog_bank_t an,
        input logic [2:0] dma);
    if (!in_page(addr)) begin
        return 8'hFF;
    end
    if (!page_open(addr, plus, asic_on)) begin
        return sd;
    end
    if (addr >= 16'h6000) begin
        case (addr[12:0])
            13'h0808, 13'h0809, 13'h080A, 13'h080B: return {2'b00, an[addr[1:0]]};
            13'h080C, 13'h080E: return 8'h3F;
            13'h080D, 13'h080F: return 8'h00;
            13'h0C0F: return {dma, 5'b00000};
            default: ;
        endcase
    end
    // unwritten RAM is unknown
    return ram_map.exists(addr[13:0]) ? ram_map[addr[13:0]] : 8'hxx;
endfunction

function automatic void apply_access(input logic [15:0] addr, input logic [7:0] data,
        input logic wr, input logic rd, input logic plus, input logic asic_on,
        input logic [7:0] sd, input analog_bank_t an, input logic [2:0] dma);
    logic [12:0] ofs;
    ofs = addr[12:0];
    if (wr && (addr[15:8] == 8'hBC) && !addr[0]) begin
        // RMR2 code carries the page bits, code 2 is the ASIC mode byte
        if (data[2:0] == 3'b001) begin
            exp_rmr2 = data[4:3];
        end else if (data[4:0] == 5'b00010) begin
            exp_enabled = plus && ((data == `PLUS_UNLOCK_A) || (data == `PLUS_UNLOCK_B) ||
                                   (data == `PLUS_UNLOCK_C));
        end
    end
    if (wr && page_open(addr, plus, asic_on)) begin
        // Odd palette bytes keep the low nibble
        if ((addr >= 16'h6000) && ofs[0] && (ofs >= 13'h0400) && (ofs <= 13'h043F)) begin
            ram_map[addr[13:0]] = {4'h0, data[3:0]};
        end else begin
            ram_map[addr[13:0]] = data;
        end
        if (addr == 16'h6800) begin
            exp_pri = data;
        end else if (addr == 16'h6804) begin
            exp_border   = data[7];
            exp_scroll_v = data[6:4];
            exp_scroll_h = data[3:0];
        end else if (addr == 16'h6805) begin
            exp_vector = data[7:3];
        end
    end
    if (rd) begin
        exp_read = predict_read(addr, plus, asic_on, sd, an, dma);
    end
endfunction

`endif

// ==== tb/tb_plus_asic.sv ====
`timescale 1ns/1ns
`include "plus_asic_params.svh"

module tb_plus_asic
    import plus_asic_pkg::*;
();

    localparam int n_unlock = 150;
    localparam int n_locked = 300;
    localparam int n_ram = 600;
    localparam int n_regs = 200;
    // Reset check, setup writes and idle cycles
    localparam int n_extra = 16;
    localparam int total_tx = 2 * n_unlock + n_locked + n_ram + n_regs + n_extra;
    localparam int timeout_cycles = 2 * total_tx + 100;

    logic         clk_sys;
    logic         reset;
    logic         plus_mode;
    logic         use_asic;
    cpu_addr_t    cpu_addr;
    byte_t        cpu_data_in;
    logic         cpu_wr;
    logic         cpu_rd;
    byte_t        cpu_data_out;
    logic         asic_unlocked;
    logic         sdram_oe;
    logic         sdram_we;
    byte_t        sdram_dout;
    analog_bank_t analog_in;
    logic [2:0]   dma_status;
    byte_t        pri_line;
    logic [3:0]   soft_scroll_h;
    logic [2:0]   soft_scroll_v;
    logic         extend_border;
    logic [4:0]   interrupt_vector;

    integer      seed = 81137;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    logic [15:0] written_q [$];

    `include "plus_asic_ref_model.svh"

    plus_asic u_plus_asic (.*);

    always #50 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("Error %s: actual %0h, expected %0h", name, actual, expected);
        end
    endtask

    // Outputs seen in a cycle, before that cycle's access reaches the model
    task automatic compare_outputs(input logic plus, input logic asic_on,
                                   input logic [15:0] addr, input logic wr, input logic rd);
        logic locked;
        locked = in_page(addr) && !page_open(addr, plus, asic_on);
        check_value("cpu_data_out", 32'(cpu_data_out), 32'(exp_read));
        check_value("asic_unlocked", 32'(asic_unlocked), 32'(exp_enabled));
        check_value("sdram_oe", 32'(sdram_oe), 32'(locked && rd));
        check_value("sdram_we", 32'(sdram_we), 32'(locked && wr));
        check_value("pri_line", 32'(pri_line), 32'(exp_pri));
        check_value("soft_scroll_h", 32'(soft_scroll_h), 32'(exp_scroll_h));
        check_value("soft_scroll_v", 32'(soft_scroll_v), 32'(exp_scroll_v));
        check_value("extend_border", 32'(extend_border), 32'(exp_border));
        check_value("interrupt_vector", 32'(interrupt_vector), 32'(exp_vector));
    endtask

    task automatic run_cycle(input logic plus, input logic asic_on, input logic [15:0] addr,
                             input logic [7:0] data, input logic wr, input logic rd);
        logic [31:0]  r_sd;
        logic [31:0]  r_an;
        logic [31:0]  r_dma;
        analog_bank_t an;
        r_sd = $random(seed);
        r_an = $random(seed);
        r_dma = $random(seed);
        an = r_an[23:0];
        @(posedge clk_sys);
        plus_mode   <= plus;
        use_asic    <= asic_on;
        cpu_addr    <= addr;
        cpu_data_in <= data;
        cpu_wr      <= wr;
        cpu_rd      <= rd;
        sdram_dout  <= r_sd[7:0];
        analog_in   <= an;
        dma_status  <= r_dma[2:0];
        @(negedge clk_sys);
        compare_outputs(plus, asic_on, addr, wr, rd);
        apply_access(addr, data, wr, rd, plus, asic_on, r_sd[7:0], an, r_dma[2:0]);
    endtask

    // Also checks the result of the last read
    task automatic idle_cycle();
        run_cycle(plus_mode, use_asic, 16'h0000, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic report_test(input string name, input int start_errors, input int count);
        $display("Test %s: %0d transactions, %0d errors", name, count,
                 error_count - start_errors);
    endtask

    task automatic unlock_test();
        int          start_errors;
        logic [31:0] r;
        logic [31:0] d;
        logic [7:0]  data;
        start_errors = error_count;
        for (int i = 0; i < n_unlock; i++) begin
            r = $random(seed);
            d = $random(seed);
            case (r[2:0])
                3'd0: data = `PLUS_UNLOCK_A;
                3'd1: data = `PLUS_UNLOCK_B;
                3'd2: data = `PLUS_UNLOCK_C;
                3'd3: data = {d[7:5], 5'b00010};
                3'd4: data = {d[7:5], d[1:0], 3'b001};
                default: data = d[7:0];
            endcase
            // Odd port address is ignored
            run_cycle(|r[21:19], 1'b1, {8'hBC, d[15:9], r[11] & r[12]}, data, 1'b1, 1'b0);
            run_cycle(|r[15:13], |r[18:16], 16'h6808 | {13'h0000, d[18:16]}, 8'h00,
                      1'b0, 1'b1);
        end
        idle_cycle();
        report_test("unlock", start_errors, 2 * n_unlock);
    endtask

    task automatic locked_test();
        int          start_errors;
        logic [31:0] r;
        logic [31:0] a;
        logic [15:0] addr;
        start_errors = error_count;
        // Mode byte with select code 2 but no unlock value
        run_cycle(1'b1, 1'b1, 16'hBC00, 8'h22, 1'b1, 1'b0);
        for (int i = 0; i < n_locked; i++) begin
            r = $random(seed);
            a = $random(seed);
            addr = 16'h4000 | {2'b00, a[13:0]};
            if (r[0]) begin
                run_cycle(r[4], r[5], addr, a[23:16], 1'b1, 1'b0);
            end else if (r[1]) begin
                run_cycle(r[4], r[5], addr, 8'h00, 1'b0, 1'b1);
            end else begin
                addr = a[15:0];
                if (in_page(addr)) begin
                    addr[15] = 1'b1;
                end
                run_cycle(r[4], r[5], addr, 8'h00, 1'b0, 1'b1);
            end
        end
        idle_cycle();
        report_test("locked_page", start_errors, n_locked);
    endtask

    task automatic open_page();
        run_cycle(1'b1, 1'b1, 16'hBC00, 8'h19, 1'b1, 1'b0);
        run_cycle(1'b1, 1'b1, 16'hBC00, `PLUS_UNLOCK_B, 1'b1, 1'b0);
    endtask

    task automatic ram_test();
        int          start_errors;
        int          idx;
        logic [31:0] r;
        logic [31:0] a;
        logic [15:0] addr;
        start_errors = error_count;
        open_page();
        written_q.delete();
        for (int i = 0; i < n_ram; i++) begin
            r = $random(seed);
            a = $random(seed);
            if ((written_q.size() == 0) || r[0]) begin
                // A quarter of the writes land in the palette
                if (r[3:2] == 2'b00) begin
                    addr = 16'h6400 | {10'h000, a[5:0]};
                end else begin
                    addr = 16'h4000 | {2'b00, a[13:0]};
                end
                written_q.push_back(addr);
                run_cycle(1'b1, 1'b1, addr, a[23:16], 1'b1, 1'b0);
            end else begin
                idx = a % written_q.size();
                run_cycle(1'b1, 1'b1, written_q[idx], 8'h00, 1'b0, 1'b1);
            end
        end
        idle_cycle();
        report_test("unlocked_ram", start_errors, n_ram);
    endtask

    task automatic register_test();
        int          start_errors;
        logic [31:0] r;
        logic [31:0] a;
        start_errors = error_count;
        open_page();
        for (int i = 0; i < n_regs; i++) begin
            r = $random(seed);
            a = $random(seed);
            case (r[1:0])
                2'b00: run_cycle(1'b1, 1'b1, 16'h6800, a[7:0], 1'b1, 1'b0);
                2'b01: run_cycle(1'b1, 1'b1, r[2] ? 16'h6805 : 16'h6804, a[7:0], 1'b1, 1'b0);
                2'b10: run_cycle(1'b1, 1'b1, 16'h6808 | {13'h0000, a[10:8]}, 8'h00,
                                 1'b0, 1'b1);
                default: run_cycle(1'b1, 1'b1, 16'h6C0F, 8'h00, 1'b0, 1'b1);
            endcase
        end
        idle_cycle();
        report_test("register_page", start_errors, n_regs);
    endtask

    initial begin
        int start_errors;
        clk_sys     = 1'b0;
        reset       = 1'b1;
        plus_mode   = 1'b0;
        use_asic    = 1'b0;
        cpu_addr    = 16'h0000;
        cpu_data_in = 8'h00;
        cpu_wr      = 1'b0;
        cpu_rd      = 1'b0;
        sdram_dout  = 8'h00;
        analog_in   = '0;
        dma_status  = 3'b000;
        clear_model();
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        start_errors = error_count;
        idle_cycle();
        report_test("reset_state", start_errors, 1);
        unlock_test();
        locked_test();
        ram_test();
        register_test();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
+incdir+tb
source/plus_asic_pkg.sv
source/asic_page_decoder.sv
source/asic_ram.sv
source/asic_register_page.sv
source/plus_asic.sv
tb/tb_plus_asic.sv

// ==== Makefile ====
# Verilator build of the Plus ASIC page testbench
VERILATOR ?= verilator
TOP       ?= tb_plus_asic
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Regression passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
